// ==== Makefile ====
# Verilator build and run of the housekeeping core testbench

TOP = timer_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
verilog/bus_pkg.sv
verilog/irq_pkg.sv
verilog/periph_bus_if.sv
verilog/sys_bus.sv
verilog/interval_timer.sv
verilog/irq_controller.sv
verilog/timer_core.sv
test/tb_clock_gen.sv
test/timer_core_assertions.sv
test/timer_core_tb.sv

// ==== test/tb_clock_gen.sv ====
/* Testbench clock source
   Free-running clock with a fixed period
*/
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real PERIOD_NS = 8.0
) (
   output logic clk_o
);

   // First rising edge half a period after time zero
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0);
         clk_o = ~clk_o;
      end
   end

endmodule

// ==== test/timer_core_assertions.sv ====
/* Bound checks on the bus handshake, settings strobe and interrupt output
*/
`timescale 1ns/1ps

module timer_core_assertions (
   input logic dsp_clk,
   input logic wb_rst,
   input logic wb_ack_i,
   input logic set_stb_i,
   input logic int_i
);

   // Ack is a single-cycle pulse
   ack_one_cycle: assert property (
      @(posedge dsp_clk) disable iff (wb_rst) wb_ack_i |=> !wb_ack_i
   ) else $error("wb_ack_o high for more than one cycle");

   // Settings strobe only together with the bus ack
   set_stb_with_ack: assert property (
      @(posedge dsp_clk) disable iff (wb_rst) set_stb_i |-> wb_ack_i
   ) else $error("settings strobe without a bus ack");

   // Quiet once reset has been seen for a full cycle
   int_low_in_reset: assert property (
      @(posedge dsp_clk) (wb_rst && $past(wb_rst)) |-> !int_i
   ) else $error("int_o high during reset");

endmodule

bind timer_core timer_core_assertions u_assertions (
   .dsp_clk   (dsp_clk),
   .wb_rst    (wb_rst),
   .wb_ack_i  (wb_ack_o),
   .set_stb_i (set_stb),
   .int_i     (int_o)
);

// ==== test/timer_core_tb.sv ====
/* Housekeeping core testbench
   Directed tests of the timers, interrupt controller and readback pages
*/
`timescale 1ns/1ps

module timer_core_tb;
   import bus_pkg::*;
   import irq_pkg::*;

   localparam int       NUM_TIMERS   = 4;
   localparam int       NUM_EXT_IRQ  = 8;
   localparam set_adr_t TIMER_BASE   = 8'd198;
   localparam int       NUM_SRC      = 2 * NUM_TIMERS + NUM_EXT_IRQ;
   localparam int       RESET_CYCLES = 16;
   localparam int       ACK_LIMIT    = 16;

   // Longest random count and period, about three cycles per bus access
   localparam int MAX_COUNT  = 71;
   localparam int MAX_PERIOD = 21;
   localparam int BUS_CYCLES = 3;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 40 * BUS_CYCLES + 3 * MAX_COUNT
                                   + 5 * MAX_PERIOD + 300;

   logic                   dsp_clk;
   logic                   wb_rst;
   bus_adr_t               wb_adr_i;
   bus_dat_t               wb_dat_i;
   logic                   wb_we_i;
   logic                   wb_stb_i;
   logic [NUM_EXT_IRQ-1:0] ext_irq_i;
   bus_dat_t               wb_dat_o;
   logic                   wb_ack_o;
   logic                   int_o;

   logic [31:0] lfsr_state;
   string       cur_test;
   int          test_count;
   int          check_count;
   int          error_count;
   int          test_err_base;
   int unsigned cycle_count;

   tb_clock_gen #(.PERIOD_NS(8.0)) u_clock (.clk_o(dsp_clk));

   timer_core #(
      .NUM_TIMERS  (NUM_TIMERS),
      .NUM_EXT_IRQ (NUM_EXT_IRQ),
      .TIMER_BASE  (TIMER_BASE)
   ) dut_i (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .wb_adr_i  (wb_adr_i),
      .wb_dat_i  (wb_dat_i),
      .wb_we_i   (wb_we_i),
      .wb_stb_i  (wb_stb_i),
      .ext_irq_i (ext_irq_i),
      .wb_dat_o  (wb_dat_o),
      .wb_ack_o  (wb_ack_o),
      .int_o     (int_o)
   );

   //////////////////////////////////////////////////
   // Random numbers and addresses

   // Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   function automatic int unsigned rand_bits(input int n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = (v << 1) | {31'd0, lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic bus_adr_t irq_adr(input reg_ofs_t ofs);
      return {PAGE_IRQ, 3'b000, ofs, 2'b00};
   endfunction

   // Settings word address sits in byte address bits 9:2
   function automatic bus_adr_t timer_adr(input int unsigned k, input int unsigned r);
      set_adr_t sa;
      sa = TIMER_BASE + set_adr_t'(2 * k + r);
      return {PAGE_SETTINGS, 2'b00, sa, 2'b00};
   endfunction

   //////////////////////////////////////////////////
   // Reporting and compare tasks

   task automatic start_test(input string name);
      cur_test      = name;
      test_err_base = error_count;
      test_count++;
   endtask

   task automatic finish_test();
      if (error_count == test_err_base) begin
         $display("%s: ok", cur_test);
      end else begin
         $display("%s: %0d error(s)", cur_test, error_count - test_err_base);
      end
   endtask

   task automatic report_problem(input string what);
      error_count++;
      $display("%s: %s", cur_test, what);
   endtask

   task automatic check_dat(input string what, input bus_dat_t exp, input bus_dat_t act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic check_idx(input string what, input irq_idx_t exp, input irq_idx_t act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
      end
   endtask

   //////////////////////////////////////////////////
   // Bus and wait tasks

   // Strobe held until ack, ack sampled on the falling edge
   task automatic bus_access(input logic we, input bus_adr_t adr, input bus_dat_t wdat,
                             output bus_dat_t rdat);
      int waited;
      waited = 0;
      rdat   = '0;
      @(posedge dsp_clk);
      #1;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      wb_we_i  = we;
      wb_stb_i = 1'b1;
      do begin
         @(negedge dsp_clk);
         waited++;
      end while (!wb_ack_o && waited < ACK_LIMIT);
      if (wb_ack_o) begin
         rdat = wb_dat_o;
      end else begin
         report_problem($sformatf("no ack within %0d cycles at address %h", ACK_LIMIT, adr));
      end
      @(posedge dsp_clk);
      #1;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_write(input bus_adr_t adr, input bus_dat_t dat);
      bus_dat_t unused;
      bus_access(1'b1, adr, dat, unused);
   endtask

   task automatic bus_read(input bus_adr_t adr, output bus_dat_t dat);
      bus_access(1'b0, adr, '0, dat);
   endtask

   task automatic wait_for_int(input int unsigned limit);
      int unsigned n;
      n = 0;
      do begin
         @(negedge dsp_clk);
         n++;
      end while (!int_o && n < limit);
      if (!int_o) begin
         report_problem($sformatf("int_o did not rise within %0d cycles", limit));
      end
   endtask

   task automatic watch_quiet(input int unsigned cycles, output logic rose);
      rose = 1'b0;
      repeat (cycles) begin
         @(negedge dsp_clk);
         if (int_o) begin
            rose = 1'b1;
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Tests

   task automatic test_reset_state();
      bus_dat_t d;
      start_test("reset_state");
      check_bit("int_o", 1'b0, int_o);
      bus_read(irq_adr(IRQ_REG_MASK), d);
      check_dat("mask", '0, d);
      bus_read(irq_adr(IRQ_REG_PENDING), d);
      check_dat("pending", '0, d);
      bus_read(irq_adr(IRQ_REG_ACTIVE), d);
      check_idx("active", IRQ_NONE, irq_idx_t'(d));
      finish_test();
   endtask

   task automatic test_one_shot();
      int unsigned k;
      int unsigned n;
      bus_dat_t    bit_k;
      bus_dat_t    d;
      logic        rose;
      start_test("one_shot");
      k     = rand_bits(2);
      n     = 8 + rand_bits(6);
      bit_k = bus_dat_t'(1) << k;
      bus_write(irq_adr(IRQ_REG_MASK), bit_k);
      bus_write(timer_adr(k, 0), bus_dat_t'(n));
      wait_for_int(n + 4);
      bus_read(irq_adr(IRQ_REG_PENDING), d);
      check_dat("pending", bit_k, d);
      bus_read(irq_adr(IRQ_REG_ACTIVE), d);
      check_idx("active", irq_idx_t'(k), irq_idx_t'(d));
      bus_write(irq_adr(IRQ_REG_PENDING), bit_k);
      check_bit("int_o after clear", 1'b0, int_o);
      watch_quiet(2 * n, rose);
      check_bit("int_o stays low", 1'b0, rose);
      bus_write(irq_adr(IRQ_REG_MASK), '0);
      finish_test();
   endtask

   task automatic test_periodic();
      int unsigned k;
      int unsigned p;
      bus_dat_t    bit_p;
      bus_dat_t    d;
      logic        rose;
      start_test("periodic");
      k     = rand_bits(2);
      p     = 6 + rand_bits(4);
      bit_p = bus_dat_t'(1) << (NUM_TIMERS + k);
      bus_write(irq_adr(IRQ_REG_MASK), bit_p);
      bus_write(timer_adr(k, 1), bus_dat_t'(p));
      wait_for_int(p + 4);
      bus_write(irq_adr(IRQ_REG_PENDING), bit_p);
      check_bit("int_o after clear", 1'b0, int_o);
      // Next wrap sets the bit again
      wait_for_int(p + 4);
      bus_read(irq_adr(IRQ_REG_PENDING), d);
      check_dat("pending again", bit_p, d);
      bus_write(timer_adr(k, 1), '0);
      bus_write(irq_adr(IRQ_REG_PENDING), bit_p);
      watch_quiet(3 * p, rose);
      check_bit("int_o after stop", 1'b0, rose);
      bus_read(irq_adr(IRQ_REG_PENDING), d);
      check_dat("pending after stop", '0, d);
      bus_write(irq_adr(IRQ_REG_MASK), '0);
      finish_test();
   endtask

   task automatic test_ext_priority();
      int unsigned k;
      int unsigned j;
      int unsigned ext_idx;
      bus_dat_t    all_src;
      bus_dat_t    bit_k;
      bus_dat_t    bit_ext;
      bus_dat_t    d;
      start_test("ext_priority");
      k       = rand_bits(2);
      j       = rand_bits(3);
      ext_idx = 2 * NUM_TIMERS + j;
      all_src = (bus_dat_t'(1) << NUM_SRC) - bus_dat_t'(1);
      bit_k   = bus_dat_t'(1) << k;
      bit_ext = bus_dat_t'(1) << ext_idx;
      bus_write(irq_adr(IRQ_REG_MASK), all_src);
      bus_write(timer_adr(k, 0), bus_dat_t'(4));
      wait_for_int(8);
      @(posedge dsp_clk);
      #1;
      ext_irq_i[j] = 1'b1;
      bus_read(irq_adr(IRQ_REG_ACTIVE), d);
      check_idx("active external", irq_idx_t'(ext_idx), irq_idx_t'(d));
      bus_write(irq_adr(IRQ_REG_MASK), all_src & ~bit_ext);
      bus_read(irq_adr(IRQ_REG_ACTIVE), d);
      check_idx("active one-shot", irq_idx_t'(k), irq_idx_t'(d));
      bus_write(irq_adr(IRQ_REG_MASK), '0);
      check_bit("int_o masked", 1'b0, int_o);
      bus_read(irq_adr(IRQ_REG_PENDING), d);
      check_dat("pending masked", bit_k | bit_ext, d);
      @(posedge dsp_clk);
      #1;
      ext_irq_i = '0;
      bus_write(irq_adr(IRQ_REG_PENDING), all_src);
      bus_read(irq_adr(IRQ_REG_PENDING), d);
      check_dat("pending cleared", '0, d);
      finish_test();
   endtask

   task automatic test_readback();
      bus_adr_t cyc_adr;
      bus_dat_t c0;
      bus_dat_t c1;
      bus_dat_t c2;
      bus_dat_t d;
      start_test("readback");
      cyc_adr = {PAGE_CYCLES, 8'h00};
      bus_read(cyc_adr, c0);
      bus_read(cyc_adr, c1);
      if (c1 <= c0) begin
         report_problem("cycle counter did not increase between two reads");
      end
      bus_read(timer_adr(0, 0), d);
      check_dat("settings read", '0, d);
      bus_write(cyc_adr, 32'hFFFF_FFFF);
      bus_read(cyc_adr, c2);
      if (c2 <= c1) begin
         report_problem("cycle counter changed by a write to its page");
      end
      bus_read(timer_adr(0, 0), d);
      check_dat("settings read after write", '0, d);
      finish_test();
   endtask

   //////////////////////////////////////////////////
   // Run control

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge dsp_clk);
         cycle_count++;
      end
      $display("Run stopped after %0d cycles without finishing", cycle_count);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      lfsr_state    = 32'd94139;
      cur_test      = "none";
      test_count    = 0;
      check_count   = 0;
      error_count   = 0;
      test_err_base = 0;
      wb_rst        = 1'b1;
      wb_adr_i      = '0;
      wb_dat_i      = '0;
      wb_we_i       = 1'b0;
      wb_stb_i      = 1'b0;
      ext_irq_i     = '0;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      #1;
      wb_rst = 1'b0;

      test_reset_state();
      test_one_shot();
      test_periodic();
      test_ext_priority();
      test_readback();

      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog/bus_pkg.sv ====
/* System bus package
   Bus widths, page decode values and register offsets of the housekeeping slaves
*/
package bus_pkg;

   //////////////////////////////////////////////////
   // Widths

   // Byte address on the system bus
   typedef logic [15:0] bus_adr_t;
   typedef logic [31:0] bus_dat_t;

   // Settings register address, taken from byte address bits 9:2
   typedef logic [7:0]  set_adr_t;

   // Word offset inside a peripheral page
   typedef logic [2:0]  reg_ofs_t;

   //////////////////////////////////////////////////
   // Address map

   // Settings window, matched on the top nibble only
   localparam logic [3:0] PAGE_SETTINGS = 4'h2;

   // Single pages, matched on the top byte
   localparam logic [7:0] PAGE_CYCLES   = 8'h33;
   localparam logic [7:0] PAGE_IRQ      = 8'h35;

   // Interrupt controller registers
   localparam reg_ofs_t IRQ_REG_MASK    = 3'd0;
   localparam reg_ofs_t IRQ_REG_PENDING = 3'd1;
   localparam reg_ofs_t IRQ_REG_ACTIVE  = 3'd2;

endpackage

// ==== verilog/interval_timer.sv ====
/* Interval timer
   One-shot down counter and periodic reload counter, loaded over the settings bus
*/
`timescale 1ns/1ps

module interval_timer #(
   parameter bus_pkg::set_adr_t BASE = 8'd198
) (
   input  logic              dsp_clk,
   input  logic              wb_rst,
   input  logic              set_stb_i,
   input  bus_pkg::set_adr_t set_adr_i,
   input  bus_pkg::bus_dat_t set_dat_i,
   output logic              onetime_o,
   output logic              periodic_o
);
   import irq_pkg::*;

   timer_cnt_t one_cnt;
   timer_cnt_t per_len;
   timer_cnt_t per_cnt;
   logic       wr_one;
   logic       wr_per;

   // Own two settings addresses
   assign wr_one = set_stb_i && (set_adr_i == BASE);
   assign wr_per = set_stb_i && (set_adr_i == BASE + 8'd1);

   //////////////////////////////////////////////////
   // One-shot

   // Count N puts the pulse N cycles after the strobe, zero cancels
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         one_cnt <= '0;
      end else if (wr_one) begin
         one_cnt <= timer_cnt_t'(set_dat_i);
      end else if (one_cnt != '0) begin
         one_cnt <= one_cnt - timer_cnt_t'(1);
      end
   end

   // Last cycle before expiry
   assign onetime_o = (one_cnt == timer_cnt_t'(1));

   //////////////////////////////////////////////////
   // Periodic

   // Period of zero parks both registers at zero
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         per_len <= '0;
         per_cnt <= '0;
      end else if (wr_per) begin
         per_len <= timer_cnt_t'(set_dat_i);
         per_cnt <= timer_cnt_t'(set_dat_i);
      end else if (per_len != '0) begin
         if (per_cnt == timer_cnt_t'(1)) begin
            per_cnt <= per_len;
         end else begin
            per_cnt <= per_cnt - timer_cnt_t'(1);
         end
      end
   end

   // Wrap cycle, repeats every per_len cycles
   assign periodic_o = (per_len != '0) && (per_cnt == timer_cnt_t'(1));

endmodule

// ==== verilog/irq_controller.sv ====
/* Interrupt controller
   Latches source pulses and lines, masks them and encodes the highest active one
*/
`timescale 1ns/1ps

module irq_controller #(
   parameter int NUM_TIMERS  = 4,
   parameter int NUM_EXT_IRQ = 8
) (
   input  logic              dsp_clk,
   input  logic              wb_rst,
   input  irq_pkg::irq_vec_t irq_src_i,
   output logic              int_o,
   periph_bus_if.periph      regs
);
   import bus_pkg::*;
   import irq_pkg::*;

   // Timer one-shots, timer periodics, then external lines
   localparam int       NUM_SRC  = 2 * NUM_TIMERS + NUM_EXT_IRQ;
   localparam irq_vec_t SRC_USED = irq_vec_t'((64'd1 << NUM_SRC) - 64'd1);

   irq_vec_t src;
   irq_vec_t mask;
   irq_vec_t pending;
   irq_vec_t enabled;
   irq_vec_t clr;
   irq_idx_t active;
   logic     wr_mask;
   logic     wr_pending;

   assign src = irq_src_i & SRC_USED;

   //////////////////////////////////////////////////
   // Register writes

   assign wr_mask    = regs.stb && regs.we && (regs.adr == IRQ_REG_MASK);
   assign wr_pending = regs.stb && regs.we && (regs.adr == IRQ_REG_PENDING);

   // Write one to clear
   assign clr = wr_pending ? irq_vec_t'(regs.wdat) : '0;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         mask <= '0;
      end else if (wr_mask) begin
         mask <= irq_vec_t'(regs.wdat) & SRC_USED;
      end
   end

   // A source still high wins over its own clear
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pending <= '0;
      end else begin
         pending <= (pending & ~clr) | src;
      end
   end

   //////////////////////////////////////////////////
   // Priority encode and output

   assign enabled = pending & mask;
   assign int_o   = |enabled;

   // Highest index wins
   always_comb begin
      active = IRQ_NONE;
      for (int i = 0; i < $bits(irq_vec_t); i++) begin
         if (enabled[i]) begin
            active = irq_idx_t'(i);
         end
      end
   end

   // Read data follows the held word offset
   always_comb begin
      case (regs.adr)
         IRQ_REG_MASK:    regs.rdat = bus_dat_t'(mask);
         IRQ_REG_PENDING: regs.rdat = bus_dat_t'(pending);
         IRQ_REG_ACTIVE:  regs.rdat = bus_dat_t'(active);
         default:         regs.rdat = '0;
      endcase
   end

endmodule

// ==== verilog/irq_pkg.sv ====
/* Timer and interrupt package
   Count and source vector types, plus the settings layout of one timer
*/
package irq_pkg;

   // Timer count or period in dsp_clk cycles
   typedef logic [31:0] timer_cnt_t;

   // One bit per interrupt source, unused sources tied low
   typedef logic [31:0] irq_vec_t;

   // Encoded source index, one bit wider than needed for 32 sources
   typedef logic [5:0]  irq_idx_t;

   // Reported when no enabled source is pending
   localparam irq_idx_t IRQ_NONE = 6'd32;

   //////////////////////////////////////////////////
   // Settings layout per timer

   // Base + 0 is the one-shot count, base + 1 the period
   localparam int TIMER_REGS = 2;

endpackage

// ==== verilog/periph_bus_if.sv ====
/* Peripheral register port
   Single-cycle register access from the bus decoder into a peripheral
*/
`timescale 1ns/1ps

interface periph_bus_if;
   import bus_pkg::*;

   // Access strobe, one cycle ahead of the bus ack
   logic     stb;
   logic     we;
   reg_ofs_t adr;
   bus_dat_t wdat;

   // Read data, combinational from adr
   bus_dat_t rdat;

   modport bus (output stb, output we, output adr, output wdat, input rdat);

   modport periph (input stb, input we, input adr, input wdat, output rdat);

endinterface

// ==== verilog/sys_bus.sv ====
/* System bus decoder
   Page decode, registered ack, read mux, settings strobes and the cycle counter
*/
`timescale 1ns/1ps

module sys_bus (
   input  logic              dsp_clk,
   input  logic              wb_rst,
   input  bus_pkg::bus_adr_t wb_adr_i,
   input  bus_pkg::bus_dat_t wb_dat_i,
   input  logic              wb_we_i,
   input  logic              wb_stb_i,
   output bus_pkg::bus_dat_t wb_dat_o,
   output logic              wb_ack_o,
   output logic              set_stb_o,
   output bus_pkg::set_adr_t set_adr_o,
   output bus_pkg::bus_dat_t set_dat_o,
   periph_bus_if.bus         irq_bus
);
   import bus_pkg::*;

   logic     req;
   logic     sel_settings;
   logic     sel_irq;
   logic     sel_cycles;
   bus_dat_t rd_mux;
   bus_dat_t cycle_cnt;

   // New request, the master holds strobe until it sees the ack
   assign req = wb_stb_i && !wb_ack_o;

   //////////////////////////////////////////////////
   // Page decode

   assign sel_settings = (wb_adr_i[15:12] == PAGE_SETTINGS);
   assign sel_irq      = (wb_adr_i[15:8] == PAGE_IRQ);
   assign sel_cycles   = (wb_adr_i[15:8] == PAGE_CYCLES);

   // Interrupt page access happens at the edge that raises the ack
   assign irq_bus.stb  = req && sel_irq;
   assign irq_bus.we   = wb_we_i;
   assign irq_bus.adr  = wb_adr_i[4:2];
   assign irq_bus.wdat = wb_dat_i;

   // Settings window and unmapped pages read as zero
   always_comb begin
      if (sel_irq) begin
         rd_mux = irq_bus.rdat;
      end else if (sel_cycles) begin
         rd_mux = cycle_cnt;
      end else begin
         rd_mux = '0;
      end
   end

   //////////////////////////////////////////////////
   // Handshake and settings strobe

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         wb_ack_o  <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         wb_ack_o  <= req;
         set_stb_o <= req && wb_we_i && sel_settings;
      end
   end

   // Data lines, only meaningful alongside their strobes
   always_ff @(posedge dsp_clk) begin
      if (req) begin
         wb_dat_o <= rd_mux;
      end
      if (req && wb_we_i && sel_settings) begin
         set_adr_o <= wb_adr_i[9:2];
         set_dat_o <= wb_dat_i;
      end
   end

   //////////////////////////////////////////////////
   // Free-running cycle counter

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 1'b1;
      end
   end

endmodule

// ==== verilog/timer_core.sv ====
/* Housekeeping core
   Bus decoder, interval timers and interrupt controller on one slave port
*/
`timescale 1ns/1ps

module timer_core #(
   parameter int                NUM_TIMERS  = 4,
   parameter int                NUM_EXT_IRQ = 8,
   parameter bus_pkg::set_adr_t TIMER_BASE  = 8'd198
) (
   input  logic                   dsp_clk,
   input  logic                   wb_rst,
   input  bus_pkg::bus_adr_t      wb_adr_i,
   input  bus_pkg::bus_dat_t      wb_dat_i,
   input  logic                   wb_we_i,
   input  logic                   wb_stb_i,
   input  logic [NUM_EXT_IRQ-1:0] ext_irq_i,
   output bus_pkg::bus_dat_t      wb_dat_o,
   output logic                   wb_ack_o,
   output logic                   int_o
);
   import bus_pkg::*;
   import irq_pkg::*;

   logic                  set_stb;
   set_adr_t              set_adr;
   bus_dat_t              set_dat;
   logic [NUM_TIMERS-1:0] onetime;
   logic [NUM_TIMERS-1:0] periodic;
   irq_vec_t              irq_src;

   periph_bus_if irq_bus ();

   //////////////////////////////////////////////////
   // Bus decode

   sys_bus u_sys_bus (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .wb_adr_i  (wb_adr_i),
      .wb_dat_i  (wb_dat_i),
      .wb_we_i   (wb_we_i),
      .wb_stb_i  (wb_stb_i),
      .wb_dat_o  (wb_dat_o),
      .wb_ack_o  (wb_ack_o),
      .set_stb_o (set_stb),
      .set_adr_o (set_adr),
      .set_dat_o (set_dat),
      .irq_bus   (irq_bus)
   );

   //////////////////////////////////////////////////
   // Timers, two settings registers each

   for (genvar k = 0; k < NUM_TIMERS; k++) begin : g_timer
      interval_timer #(
         .BASE (set_adr_t'(TIMER_BASE + TIMER_REGS * k))
      ) u_timer (
         .dsp_clk    (dsp_clk),
         .wb_rst     (wb_rst),
         .set_stb_i  (set_stb),
         .set_adr_i  (set_adr),
         .set_dat_i  (set_dat),
         .onetime_o  (onetime[k]),
         .periodic_o (periodic[k])
      );
   end

   // Upper sources tie off to zero
   assign irq_src = irq_vec_t'({ext_irq_i, periodic, onetime});

   irq_controller #(
      .NUM_TIMERS  (NUM_TIMERS),
      .NUM_EXT_IRQ (NUM_EXT_IRQ)
   ) u_irq (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .irq_src_i (irq_src),
      .int_o     (int_o),
      .regs      (irq_bus)
   );

endmodule
